// File: logic/cpu_pkg.sv
package cpu_pkg;

    localparam int XLEN = 32;

    typedef logic [XLEN-1:0] word_t;
    typedef logic [4:0]      reg_addr_t;

    localparam word_t RESET_PC = 32'h0000_0000;
    // add x0,x0,x0
    localparam word_t NOP_INST = 32'h0000_0033;

    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_PASS_B
    } alu_op_e;

    typedef enum logic [1:0] {WB_ALU, WB_PC4, WB_MEM} wb_sel_e;
    typedef enum logic [2:0] {BR_NONE, BR_EQ, BR_NE, BR_LT, BR_GE} br_type_e;
    typedef enum logic [2:0] {IMM_I, IMM_S, IMM_B, IMM_U, IMM_J} imm_type_e;
    typedef enum logic [1:0] {FWD_NONE, FWD_MEM, FWD_WB} fwd_sel_e;

    // all-zero is a bubble
    typedef struct packed {
        logic     rf_we;
        wb_sel_e  wb_sel;
        alu_op_e  alu_op;
        logic     alu_a_pc;
        logic     alu_b_imm;
        br_type_e br_type;
        logic     jalr;
        logic     mem_we;
        logic     mem_re;
    } ctrl_t;

    typedef struct packed {
        word_t pc;
        word_t pc_plus4;
        word_t inst;
    } if_id_t;

    typedef struct packed {
        word_t     pc;
        word_t     pc_plus4;
        reg_addr_t rs1;
        reg_addr_t rs2;
        reg_addr_t rd;
        word_t     rs1_data;
        word_t     rs2_data;
        word_t     imm;
        ctrl_t     ctrl;
    } id_ex_t;

    typedef struct packed {
        word_t     pc_plus4;
        reg_addr_t rd;
        word_t     alu_result;
        word_t     store_data;
        ctrl_t     ctrl;
    } ex_mem_t;

    typedef struct packed {
        reg_addr_t rd;
        logic      rf_we;
        wb_sel_e   wb_sel;
        word_t     alu_result;
        word_t     pc_plus4;
        word_t     mem_data;
    } mem_wb_t;

endpackage

// File: logic/fetch_stage.sv
module fetch_stage (
    input  logic            clk,
    input  logic            arst_n,
    input  logic            stall,
    input  logic            flush_id,
    input  logic            jal_redirect,
    input  cpu_pkg::word_t  jal_target,
    input  logic            ex_redirect,
    input  cpu_pkg::word_t  ex_target,
    output cpu_pkg::word_t  im_addr,
    input  cpu_pkg::word_t  im_data,
    output cpu_pkg::if_id_t if_id
);
    import cpu_pkg::*;

    word_t pc;
    word_t pc_plus4;
    word_t pc_next;

    assign pc_plus4 = pc + 32'd4;
    assign im_addr  = pc;

    // older redirect wins
    always_comb begin
        if (ex_redirect) begin
            pc_next = ex_target;
        end else if (jal_redirect) begin
            pc_next = jal_target;
        end else if (stall) begin
            pc_next = pc;
        end else begin
            pc_next = pc_plus4;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pc    <= RESET_PC;
            if_id <= '{pc: RESET_PC, pc_plus4: RESET_PC, inst: NOP_INST};
        end else begin
            pc <= pc_next;
            if (flush_id) begin
                if_id <= '{pc: pc, pc_plus4: pc_plus4, inst: NOP_INST};
            end else if (!stall) begin
                if_id <= '{pc: pc, pc_plus4: pc_plus4, inst: im_data};
            end
        end
    end

endmodule

// File: logic/reg_file.sv
module reg_file (
    input  logic               clk,
    input  logic               arst_n,
    input  cpu_pkg::reg_addr_t ra0,
    input  cpu_pkg::reg_addr_t ra1,
    input  cpu_pkg::reg_addr_t wa,
    input  logic               we,
    input  cpu_pkg::word_t     wd,
    output cpu_pkg::word_t     rd0,
    output cpu_pkg::word_t     rd1,
    input  cpu_pkg::reg_addr_t dbg_addr,
    output cpu_pkg::word_t     dbg_data
);
    import cpu_pkg::*;

    word_t regs [1:31];

    // x0 reads zero, a same-cycle write shows through
    function automatic word_t read_port(reg_addr_t addr);
        if (addr == '0) begin
            return '0;
        end else if (we && wa == addr) begin
            return wd;
        end
        return regs[addr];
    endfunction

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && wa != '0) begin
            regs[wa] <= wd;
        end
    end

    always_comb begin
        rd0      = read_port(ra0);
        rd1      = read_port(ra1);
        dbg_data = read_port(dbg_addr);
    end

endmodule

// File: logic/decode_stage.sv
module decode_stage (
    input  logic               clk,
    input  logic               arst_n,
    input  cpu_pkg::if_id_t    if_id,
    input  logic               stall,
    input  logic               flush_ex,
    input  logic               wb_we,
    input  cpu_pkg::reg_addr_t wb_addr,
    input  cpu_pkg::word_t     wb_data,
    input  cpu_pkg::reg_addr_t dbg_reg_addr,
    output cpu_pkg::id_ex_t    id_ex,
    output cpu_pkg::word_t     dbg_reg_data,
    output logic               jal_redirect,
    output cpu_pkg::word_t     jal_target,
    output cpu_pkg::reg_addr_t rs1,
    output cpu_pkg::reg_addr_t rs2
);
    import cpu_pkg::*;

    word_t      inst;
    logic [6:0] opcode;
    logic [2:0] funct3;
    ctrl_t      ctrl;
    imm_type_e  imm_type;
    logic       use_rs1;
    logic       use_rs2;
    word_t      imm;
    word_t      rs1_data;
    word_t      rs2_data;

    function automatic alu_op_e alu_decode(logic [2:0] f3, logic sub);
        case (f3)
            3'b000:  return sub ? ALU_SUB : ALU_ADD;
            3'b010:  return ALU_SLT;
            3'b100:  return ALU_XOR;
            3'b110:  return ALU_OR;
            3'b111:  return ALU_AND;
            default: return ALU_ADD;
        endcase
    endfunction

    function automatic br_type_e br_decode(logic [2:0] f3);
        case (f3)
            3'b000:  return BR_EQ;
            3'b001:  return BR_NE;
            3'b100:  return BR_LT;
            3'b101:  return BR_GE;
            default: return BR_NONE;
        endcase
    endfunction

    assign inst   = if_id.inst;
    assign opcode = inst[6:0];
    assign funct3 = inst[14:12];

    always_comb begin
        ctrl     = '0;
        imm_type = IMM_I;
        use_rs1  = 1'b0;
        use_rs2  = 1'b0;
        case (opcode)
            OPC_OP: begin
                ctrl.rf_we  = 1'b1;
                ctrl.alu_op = alu_decode(funct3, inst[30]);
                use_rs1     = 1'b1;
                use_rs2     = 1'b1;
            end
            OPC_OP_IMM: begin
                ctrl.rf_we     = 1'b1;
                ctrl.alu_op    = alu_decode(funct3, 1'b0);
                ctrl.alu_b_imm = 1'b1;
                use_rs1        = 1'b1;
            end
            OPC_LUI: begin
                ctrl.rf_we     = 1'b1;
                ctrl.alu_op    = ALU_PASS_B;
                ctrl.alu_b_imm = 1'b1;
                imm_type       = IMM_U;
            end
            OPC_AUIPC: begin
                ctrl.rf_we     = 1'b1;
                ctrl.alu_a_pc  = 1'b1;
                ctrl.alu_b_imm = 1'b1;
                imm_type       = IMM_U;
            end
            OPC_LOAD: begin
                ctrl.rf_we     = 1'b1;
                ctrl.wb_sel    = WB_MEM;
                ctrl.alu_b_imm = 1'b1;
                ctrl.mem_re    = 1'b1;
                use_rs1        = 1'b1;
            end
            OPC_STORE: begin
                ctrl.mem_we    = 1'b1;
                ctrl.alu_b_imm = 1'b1;
                imm_type       = IMM_S;
                use_rs1        = 1'b1;
                use_rs2        = 1'b1;
            end
            OPC_BRANCH: begin
                // alu forms the target, the compare runs beside it
                ctrl.br_type   = br_decode(funct3);
                ctrl.alu_a_pc  = 1'b1;
                ctrl.alu_b_imm = 1'b1;
                imm_type       = IMM_B;
                use_rs1        = 1'b1;
                use_rs2        = 1'b1;
            end
            OPC_JAL: begin
                ctrl.rf_we  = 1'b1;
                ctrl.wb_sel = WB_PC4;
                imm_type    = IMM_J;
            end
            OPC_JALR: begin
                ctrl.rf_we     = 1'b1;
                ctrl.wb_sel    = WB_PC4;
                ctrl.jalr      = 1'b1;
                ctrl.alu_b_imm = 1'b1;
                use_rs1        = 1'b1;
            end
            default: ;
        endcase
    end

    always_comb begin
        case (imm_type)
            IMM_S:   imm = {{20{inst[31]}}, inst[31:25], inst[11:7]};
            IMM_B:   imm = {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
            IMM_U:   imm = {inst[31:12], 12'b0};
            IMM_J:   imm = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
            default: imm = {{20{inst[31]}}, inst[31:20]};
        endcase
    end

    // unused source fields read as x0 so they never cause a hazard
    assign rs1 = use_rs1 ? inst[19:15] : '0;
    assign rs2 = use_rs2 ? inst[24:20] : '0;

    assign jal_redirect = (opcode == OPC_JAL);
    assign jal_target   = if_id.pc + imm;

    reg_file reg_file_inst (
        .clk      (clk),
        .arst_n   (arst_n),
        .ra0      (rs1),
        .ra1      (rs2),
        .wa       (wb_addr),
        .we       (wb_we),
        .wd       (wb_data),
        .rd0      (rs1_data),
        .rd1      (rs2_data),
        .dbg_addr (dbg_reg_addr),
        .dbg_data (dbg_reg_data)
    );

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            id_ex <= '0;
        end else if (stall || flush_ex) begin
            id_ex <= '0;
        end else begin
            id_ex <= '{pc: if_id.pc, pc_plus4: if_id.pc_plus4,
                       rs1: rs1, rs2: rs2, rd: inst[11:7],
                       rs1_data: rs1_data, rs2_data: rs2_data,
                       imm: imm, ctrl: ctrl};
        end
    end

endmodule

// File: logic/execute_stage.sv
module execute_stage (
    input  logic              clk,
    input  logic              arst_n,
    input  cpu_pkg::id_ex_t   id_ex,
    input  cpu_pkg::fwd_sel_e fwd_a,
    input  cpu_pkg::fwd_sel_e fwd_b,
    input  cpu_pkg::word_t    mem_fwd_data,
    input  cpu_pkg::word_t    wb_fwd_data,
    output cpu_pkg::ex_mem_t  ex_mem,
    output logic              ex_redirect,
    output cpu_pkg::word_t    ex_target
);
    import cpu_pkg::*;

    word_t op_a;
    word_t op_b;
    word_t alu_a;
    word_t alu_b;
    word_t alu_result;
    logic  br_taken;

    function automatic word_t fwd_mux(fwd_sel_e sel, word_t rf_val);
        case (sel)
            FWD_MEM: return mem_fwd_data;
            FWD_WB:  return wb_fwd_data;
            default: return rf_val;
        endcase
    endfunction

    always_comb begin
        op_a  = fwd_mux(fwd_a, id_ex.rs1_data);
        op_b  = fwd_mux(fwd_b, id_ex.rs2_data);
        alu_a = id_ex.ctrl.alu_a_pc ? id_ex.pc : op_a;
        alu_b = id_ex.ctrl.alu_b_imm ? id_ex.imm : op_b;
    end

    always_comb begin
        case (id_ex.ctrl.alu_op)
            ALU_SUB:    alu_result = alu_a - alu_b;
            ALU_AND:    alu_result = alu_a & alu_b;
            ALU_OR:     alu_result = alu_a | alu_b;
            ALU_XOR:    alu_result = alu_a ^ alu_b;
            ALU_SLT:    alu_result = {{(XLEN-1){1'b0}}, $signed(alu_a) < $signed(alu_b)};
            ALU_PASS_B: alu_result = alu_b;
            default:    alu_result = alu_a + alu_b;
        endcase
    end

    // compare uses the register operands, not the alu inputs
    always_comb begin
        case (id_ex.ctrl.br_type)
            BR_EQ:   br_taken = (op_a == op_b);
            BR_NE:   br_taken = (op_a != op_b);
            BR_LT:   br_taken = ($signed(op_a) < $signed(op_b));
            BR_GE:   br_taken = ($signed(op_a) >= $signed(op_b));
            default: br_taken = 1'b0;
        endcase
    end

    assign ex_redirect = br_taken || id_ex.ctrl.jalr;
    assign ex_target   = id_ex.ctrl.jalr ? {alu_result[XLEN-1:1], 1'b0} : alu_result;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ex_mem <= '0;
        end else begin
            ex_mem <= '{pc_plus4: id_ex.pc_plus4, rd: id_ex.rd, alu_result: alu_result,
                        store_data: op_b, ctrl: id_ex.ctrl};
        end
    end

endmodule

// File: logic/hazard_unit.sv
module hazard_unit (
    input  cpu_pkg::reg_addr_t rs1,
    input  cpu_pkg::reg_addr_t rs2,
    input  cpu_pkg::id_ex_t    id_ex,
    input  cpu_pkg::ex_mem_t   ex_mem,
    input  logic               wb_we,
    input  cpu_pkg::reg_addr_t wb_addr,
    input  logic               jal_redirect,
    input  logic               ex_redirect,
    output logic               stall,
    output logic               flush_id,
    output logic               flush_ex,
    output cpu_pkg::fwd_sel_e  fwd_a,
    output cpu_pkg::fwd_sel_e  fwd_b
);
    import cpu_pkg::*;

    logic load_in_ex;

    // memory stage is younger than writeback so it is checked first
    function automatic fwd_sel_e fwd_pick(reg_addr_t src);
        if (src == '0) begin
            return FWD_NONE;
        end else if (ex_mem.ctrl.rf_we && !ex_mem.ctrl.mem_re && ex_mem.rd == src) begin
            return FWD_MEM;
        end else if (wb_we && wb_addr == src) begin
            return FWD_WB;
        end
        return FWD_NONE;
    endfunction

    always_comb begin
        fwd_a = fwd_pick(id_ex.rs1);
        fwd_b = fwd_pick(id_ex.rs2);
    end

    assign load_in_ex = id_ex.ctrl.mem_re && id_ex.rd != '0;
    assign stall      = load_in_ex && (id_ex.rd == rs1 || id_ex.rd == rs2);

    // a taken branch also kills the instruction in decode
    assign flush_id = ex_redirect || jal_redirect;
    assign flush_ex = ex_redirect;

endmodule

// File: logic/mem_wb_stage.sv
module mem_wb_stage (
    input  logic               clk,
    input  logic               arst_n,
    input  cpu_pkg::ex_mem_t   ex_mem,
    input  cpu_pkg::word_t     mem_rdata,
    output cpu_pkg::word_t     mem_addr,
    output cpu_pkg::word_t     mem_wdata,
    output logic               mem_we,
    output logic               wb_we,
    output cpu_pkg::reg_addr_t wb_addr,
    output cpu_pkg::word_t     wb_data,
    output cpu_pkg::word_t     mem_fwd_data
);
    import cpu_pkg::*;

    mem_wb_t mem_wb;

    assign mem_addr  = ex_mem.alu_result;
    assign mem_wdata = ex_mem.store_data;
    assign mem_we    = ex_mem.ctrl.mem_we;

    // link value for jumps still in flight
    assign mem_fwd_data = (ex_mem.ctrl.wb_sel == WB_PC4) ? ex_mem.pc_plus4 : ex_mem.alu_result;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            mem_wb <= '0;
        end else begin
            mem_wb <= '{rd: ex_mem.rd, rf_we: ex_mem.ctrl.rf_we, wb_sel: ex_mem.ctrl.wb_sel,
                        alu_result: ex_mem.alu_result, pc_plus4: ex_mem.pc_plus4,
                        mem_data: mem_rdata};
        end
    end

    assign wb_we   = mem_wb.rf_we;
    assign wb_addr = mem_wb.rd;

    always_comb begin
        case (mem_wb.wb_sel)
            WB_PC4:  wb_data = mem_wb.pc_plus4;
            WB_MEM:  wb_data = mem_wb.mem_data;
            default: wb_data = mem_wb.alu_result;
        endcase
    end

endmodule

// File: logic/cpu_top.sv
module cpu_top (
    input  logic               clk,
    input  logic               arst_n,
    output cpu_pkg::word_t     im_addr,
    input  cpu_pkg::word_t     im_data,
    output cpu_pkg::word_t     mem_addr,
    output cpu_pkg::word_t     mem_wdata,
    output logic               mem_we,
    input  cpu_pkg::word_t     mem_rdata,
    input  cpu_pkg::reg_addr_t dbg_reg_addr,
    output cpu_pkg::word_t     dbg_reg_data
);
    import cpu_pkg::*;

    if_id_t    if_id;
    id_ex_t    id_ex;
    ex_mem_t   ex_mem;
    logic      stall;
    logic      flush_id;
    logic      flush_ex;
    fwd_sel_e  fwd_a;
    fwd_sel_e  fwd_b;
    logic      jal_redirect;
    word_t     jal_target;
    logic      ex_redirect;
    word_t     ex_target;
    reg_addr_t rs1;
    reg_addr_t rs2;
    logic      wb_we;
    reg_addr_t wb_addr;
    word_t     wb_data;
    word_t     mem_fwd_data;

    fetch_stage fetch_stage_inst (
        .clk          (clk),
        .arst_n       (arst_n),
        .stall        (stall),
        .flush_id     (flush_id),
        .jal_redirect (jal_redirect),
        .jal_target   (jal_target),
        .ex_redirect  (ex_redirect),
        .ex_target    (ex_target),
        .im_addr      (im_addr),
        .im_data      (im_data),
        .if_id        (if_id)
    );

    decode_stage decode_stage_inst (
        .clk          (clk),
        .arst_n       (arst_n),
        .if_id        (if_id),
        .stall        (stall),
        .flush_ex     (flush_ex),
        .wb_we        (wb_we),
        .wb_addr      (wb_addr),
        .wb_data      (wb_data),
        .dbg_reg_addr (dbg_reg_addr),
        .id_ex        (id_ex),
        .dbg_reg_data (dbg_reg_data),
        .jal_redirect (jal_redirect),
        .jal_target   (jal_target),
        .rs1          (rs1),
        .rs2          (rs2)
    );

    execute_stage execute_stage_inst (
        .clk          (clk),
        .arst_n       (arst_n),
        .id_ex        (id_ex),
        .fwd_a        (fwd_a),
        .fwd_b        (fwd_b),
        .mem_fwd_data (mem_fwd_data),
        .wb_fwd_data  (wb_data),
        .ex_mem       (ex_mem),
        .ex_redirect  (ex_redirect),
        .ex_target    (ex_target)
    );

    mem_wb_stage mem_wb_stage_inst (
        .clk          (clk),
        .arst_n       (arst_n),
        .ex_mem       (ex_mem),
        .mem_rdata    (mem_rdata),
        .mem_addr     (mem_addr),
        .mem_wdata    (mem_wdata),
        .mem_we       (mem_we),
        .wb_we        (wb_we),
        .wb_addr      (wb_addr),
        .wb_data      (wb_data),
        .mem_fwd_data (mem_fwd_data)
    );

    hazard_unit hazard_unit_inst (
        .rs1          (rs1),
        .rs2          (rs2),
        .id_ex        (id_ex),
        .ex_mem       (ex_mem),
        .wb_we        (wb_we),
        .wb_addr      (wb_addr),
        .jal_redirect (jal_redirect),
        .ex_redirect  (ex_redirect),
        .stall        (stall),
        .flush_id     (flush_id),
        .flush_ex     (flush_ex),
        .fwd_a        (fwd_a),
        .fwd_b        (fwd_b)
    );

endmodule

// File: dv/cpu_chk.sv
module cpu_chk (
    input logic           clk,
    input logic           arst_n,
    input cpu_pkg::word_t im_addr,
    input cpu_pkg::word_t mem_addr,
    input logic           mem_we
);
    timeunit 1ns;
    timeprecision 1ps;

    im_aligned: assert property (@(posedge clk) disable iff (!arst_n)
        im_addr[1:0] == 2'b00)
        else $error("im_addr %h is not word aligned", im_addr);

    // stores write whole words
    store_aligned: assert property (@(posedge clk) disable iff (!arst_n)
        mem_we |-> mem_addr[1:0] == 2'b00)
        else $error("store to mem_addr %h is not word aligned", mem_addr);

    im_addr_known: assert property (@(posedge clk) disable iff (!arst_n)
        !$isunknown(im_addr))
        else $error("im_addr is unknown after reset");

    mem_we_known: assert property (@(posedge clk) disable iff (!arst_n)
        !$isunknown(mem_we))
        else $error("mem_we is unknown after reset");

endmodule

bind cpu_top cpu_chk cpu_chk_inst (
    .clk      (clk),
    .arst_n   (arst_n),
    .im_addr  (im_addr),
    .mem_addr (mem_addr),
    .mem_we   (mem_we)
);

// File: dv/cpu_tb.sv
module cpu_tb;
    timeunit 1ns;
    timeprecision 1ps;
    import cpu_pkg::*;

    localparam int    IMEM_WORDS   = 64;
    localparam int    DMEM_WORDS   = 64;
    localparam int    HALT_TIMEOUT = 300;
    // last instruction before the halt loop needs this many edges to retire
    localparam int    DRAIN_CYCLES = 5;
    localparam word_t HALT_ADDR    = 32'h0000_00B0;
    localparam word_t STORE_ADDR   = 32'h0000_0044;

    localparam logic [2:0] F3_ADD = 3'b000;
    localparam logic [2:0] F3_SLT = 3'b010;
    localparam logic [2:0] F3_XOR = 3'b100;
    localparam logic [2:0] F3_OR  = 3'b110;
    localparam logic [2:0] F3_AND = 3'b111;
    localparam logic [2:0] F3_BEQ = 3'b000;
    localparam logic [2:0] F3_BNE = 3'b001;
    localparam logic [2:0] F3_BLT = 3'b100;
    localparam logic [2:0] F3_BGE = 3'b101;

    logic      clk;
    logic      arst_n;
    word_t     im_addr;
    word_t     im_data;
    word_t     mem_addr;
    word_t     mem_wdata;
    logic      mem_we;
    word_t     mem_rdata;
    reg_addr_t dbg_reg_addr;
    word_t     dbg_reg_data;

    word_t imem [IMEM_WORDS];
    word_t dmem [DMEM_WORDS];
    word_t model [32];
    int    error_count;
    int    check_count;
    int    tests_run;
    int    port_errors;

    cpu_top cpu_top_inst (
        .clk          (clk),
        .arst_n       (arst_n),
        .im_addr      (im_addr),
        .im_data      (im_data),
        .mem_addr     (mem_addr),
        .mem_wdata    (mem_wdata),
        .mem_we       (mem_we),
        .mem_rdata    (mem_rdata),
        .dbg_reg_addr (dbg_reg_addr),
        .dbg_reg_data (dbg_reg_data)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    assign im_data   = imem[im_addr[7:2]];
    assign mem_rdata = dmem[mem_addr[7:2]];

    function automatic word_t fill_word(input int idx);
        return 32'hD00D_0000 | (word_t'(idx) << 2);
    endfunction

    // data memory is filled while reset is held
    always @(posedge clk) begin
        if (!arst_n) begin
            for (int i = 0; i < DMEM_WORDS; i++) begin
                dmem[i] <= fill_word(i);
            end
        end else if (mem_we) begin
            dmem[mem_addr[7:2]] <= mem_wdata;
        end
    end

    always @(negedge clk) begin
        if (arst_n) begin
            assert (!$isunknown(im_addr) && im_addr[1:0] == 2'b00) else begin
                $display("** Error at %0t ns: im_addr %h misaligned or unknown", $time, im_addr);
                port_errors++;
            end
            assert (!$isunknown(mem_we) && !(mem_we && mem_addr[1:0] != 2'b00)) else begin
                $display("** Error at %0t ns: bad store port, mem_we %b mem_addr %h",
                         $time, mem_we, mem_addr);
                port_errors++;
            end
        end
    end

    function automatic word_t sext12(input logic [11:0] imm);
        return {{20{imm[11]}}, imm};
    endfunction

    function automatic word_t alu_rr(input logic [2:0] f3, input logic sub,
                                     input reg_addr_t rd, input reg_addr_t rs1,
                                     input reg_addr_t rs2);
        return {(sub ? 7'h20 : 7'h00), rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic word_t alu_ri(input logic [2:0] f3, input reg_addr_t rd,
                                     input reg_addr_t rs1, input logic [11:0] imm);
        return {imm, rs1, f3, rd, 7'b0010011};
    endfunction

    function automatic word_t upper(input logic [6:0] opc, input reg_addr_t rd,
                                    input logic [19:0] imm);
        return {imm, rd, opc};
    endfunction

    function automatic word_t load_word(input reg_addr_t rd, input reg_addr_t rs1,
                                        input logic [11:0] imm);
        return {imm, rs1, 3'b010, rd, 7'b0000011};
    endfunction

    function automatic word_t store_word(input reg_addr_t rs2, input reg_addr_t rs1,
                                         input logic [11:0] imm);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
    endfunction

    function automatic word_t branch(input logic [2:0] f3, input reg_addr_t rs1,
                                     input reg_addr_t rs2, input logic [12:0] off);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
    endfunction

    function automatic word_t jump(input reg_addr_t rd, input logic [20:0] off);
        return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
    endfunction

    function automatic word_t jump_reg(input reg_addr_t rd, input reg_addr_t rs1,
                                       input logic [11:0] imm);
        return {imm, rs1, 3'b000, rd, 7'b1100111};
    endfunction

    task automatic load_program();
        // unused words are addi x0 no-ops tagged with their address
        for (int i = 0; i < IMEM_WORDS; i++) begin
            imem[i] = alu_ri(F3_ADD, 5'd0, 5'd0, 12'(i * 4));
        end
        // dependent alu chain
        imem[0]  = alu_ri(F3_ADD, 5'd1, 5'd0, 12'd5);
        imem[1]  = alu_ri(F3_ADD, 5'd2, 5'd1, 12'hFF4);
        imem[2]  = alu_rr(F3_ADD, 1'b0, 5'd3, 5'd1, 5'd2);
        imem[3]  = alu_rr(F3_ADD, 1'b1, 5'd4, 5'd1, 5'd2);
        imem[4]  = alu_rr(F3_AND, 1'b0, 5'd5, 5'd4, 5'd2);
        imem[5]  = alu_rr(F3_OR, 1'b0, 5'd6, 5'd5, 5'd1);
        imem[6]  = alu_rr(F3_XOR, 1'b0, 5'd7, 5'd6, 5'd4);
        imem[7]  = alu_rr(F3_SLT, 1'b0, 5'd8, 5'd2, 5'd1);
        imem[8]  = alu_ri(F3_AND, 5'd9, 5'd6, 12'd6);
        imem[9]  = alu_ri(F3_OR, 5'd10, 5'd9, 12'h030);
        imem[10] = alu_ri(F3_XOR, 5'd11, 5'd10, 12'hFFF);
        imem[11] = alu_ri(F3_SLT, 5'd12, 5'd11, 12'd0);
        imem[12] = upper(7'b0110111, 5'd13, 20'h12345);
        imem[13] = alu_ri(F3_ADD, 5'd13, 5'd13, 12'h678);
        imem[14] = upper(7'b0010111, 5'd14, 20'h00001);
        imem[15] = alu_ri(F3_ADD, 5'd14, 5'd14, 12'd8);
        // store, load and an immediate use of the load
        imem[16] = alu_ri(F3_ADD, 5'd15, 5'd0, 12'h040);
        imem[17] = store_word(5'd14, 5'd15, 12'd4);
        imem[18] = load_word(5'd16, 5'd15, 12'd4);
        imem[19] = alu_rr(F3_ADD, 1'b0, 5'd17, 5'd16, 5'd1);
        imem[20] = alu_ri(F3_ADD, 5'd0, 5'd1, 12'd99);
        imem[21] = alu_rr(F3_ADD, 1'b0, 5'd18, 5'd0, 5'd1);
        // markers in the shadow of branches and jumps must never retire
        imem[22] = branch(F3_BEQ, 5'd1, 5'd1, 13'd12);
        imem[23] = alu_ri(F3_ADD, 5'd19, 5'd0, 12'd1);
        imem[24] = alu_ri(F3_ADD, 5'd19, 5'd0, 12'd2);
        imem[25] = branch(F3_BNE, 5'd1, 5'd1, 13'd8);
        imem[26] = alu_ri(F3_ADD, 5'd20, 5'd0, 12'd3);
        imem[27] = branch(F3_BLT, 5'd2, 5'd1, 13'd12);
        imem[28] = alu_ri(F3_ADD, 5'd21, 5'd0, 12'd1);
        imem[29] = alu_ri(F3_ADD, 5'd21, 5'd0, 12'd2);
        imem[30] = branch(F3_BGE, 5'd2, 5'd1, 13'd8);
        imem[31] = alu_ri(F3_ADD, 5'd22, 5'd0, 12'd4);
        imem[32] = jump(5'd23, 21'd12);
        imem[33] = alu_ri(F3_ADD, 5'd24, 5'd0, 12'd1);
        imem[34] = alu_ri(F3_ADD, 5'd24, 5'd0, 12'd2);
        imem[35] = alu_ri(F3_ADD, 5'd25, 5'd0, 12'h0A0);
        imem[36] = jump_reg(5'd26, 5'd25, 12'd1);
        imem[37] = alu_ri(F3_ADD, 5'd27, 5'd0, 12'd1);
        imem[38] = alu_ri(F3_ADD, 5'd27, 5'd0, 12'd2);
        imem[39] = alu_ri(F3_ADD, 5'd27, 5'd0, 12'd3);
        imem[40] = alu_rr(F3_ADD, 1'b0, 5'd28, 5'd26, 5'd23);
        imem[41] = alu_ri(F3_ADD, 5'd29, 5'd0, 12'd7);
        imem[42] = alu_ri(F3_ADD, 5'd30, 5'd0, 12'd8);
        imem[43] = alu_ri(F3_ADD, 5'd31, 5'd0, 12'd9);
        imem[44] = jump(5'd0, 21'd0);
    endtask

    // RV32I register values with zero where nothing may write
    task automatic build_expected();
        for (int r = 0; r < 32; r++) begin
            model[r] = '0;
        end
        model[1]  = sext12(12'd5);
        model[2]  = model[1] + sext12(12'hFF4);
        model[3]  = model[1] + model[2];
        model[4]  = model[1] - model[2];
        model[5]  = model[4] & model[2];
        model[6]  = model[5] | model[1];
        model[7]  = model[6] ^ model[4];
        model[8]  = ($signed(model[2]) < $signed(model[1])) ? 32'd1 : 32'd0;
        model[9]  = model[6] & sext12(12'd6);
        model[10] = model[9] | sext12(12'h030);
        model[11] = model[10] ^ sext12(12'hFFF);
        model[12] = ($signed(model[11]) < $signed(32'd0)) ? 32'd1 : 32'd0;
        model[13] = {20'h12345, 12'h000} + sext12(12'h678);
        model[14] = 32'h38 + {20'h00001, 12'h000} + sext12(12'd8);
        model[15] = sext12(12'h040);
        model[16] = model[14];
        model[17] = model[16] + model[1];
        model[18] = model[1];
        model[20] = 32'd3;
        model[22] = 32'd4;
        model[23] = 32'h80 + 32'd4;
        model[25] = 32'hA0;
        model[26] = 32'h90 + 32'd4;
        model[28] = model[26] + model[23];
        model[29] = 32'd7;
        model[30] = 32'd8;
        model[31] = 32'd9;
    endtask

    task automatic expect_word(input string what, input word_t got, input word_t expected);
        check_count++;
        assert (got == expected) else begin
            $display("** Error at %0t ns: %s is %h, expected %h", $time, what, got, expected);
            error_count++;
        end
    endtask

    task automatic expect_reg(input int idx);
        word_t got;
        @(negedge clk);
        dbg_reg_addr = reg_addr_t'(idx);
        @(negedge clk);
        got = dbg_reg_data;
        expect_word($sformatf("x%0d", idx), got, model[idx]);
    endtask

    task automatic expect_reg_range(input int first, input int last);
        for (int r = first; r <= last; r++) begin
            expect_reg(r);
        end
    endtask

    task automatic report_test(input string name, input int errors_before,
                               input int checks_before);
        tests_run++;
        $display("test %s: %0d checks, %0d failed", name,
                 check_count - checks_before, error_count - errors_before);
    endtask

    task automatic wait_for_halt(output bit reached);
        reached = 1'b0;
        for (int cyc = 0; cyc < HALT_TIMEOUT && !reached; cyc++) begin
            @(negedge clk);
            reached = (im_addr == HALT_ADDR);
        end
    endtask

    task automatic run_reg_tests();
        int e0;
        int c0;
        e0 = error_count;
        c0 = check_count;
        expect_reg_range(1, 14);
        report_test("forwarding", e0, c0);
        e0 = error_count;
        c0 = check_count;
        expect_reg_range(15, 17);
        expect_word("dmem word at 0x44", dmem[STORE_ADDR[7:2]], model[14]);
        report_test("load_use", e0, c0);
        e0 = error_count;
        c0 = check_count;
        expect_reg_range(19, 31);
        report_test("control_flow", e0, c0);
        e0 = error_count;
        c0 = check_count;
        expect_reg(0);
        expect_reg(18);
        report_test("debug_x0", e0, c0);
        e0 = error_count;
        c0 = check_count;
        check_count++;
        assert (port_errors == 0) else begin
            $display("port rules were broken %0d times during the run", port_errors);
            error_count++;
        end
        report_test("port_rules", e0, c0);
    endtask

    initial begin
        int e0;
        int c0;
        bit halted;
        arst_n       = 1'b0;
        dbg_reg_addr = '0;
        error_count  = 0;
        check_count  = 0;
        tests_run    = 0;
        port_errors  = 0;
        load_program();
        build_expected();

        e0 = error_count;
        c0 = check_count;
        repeat (3) @(negedge clk);
        arst_n = 1'b1;
        expect_word("im_addr at release", im_addr, RESET_PC);
        expect_word("mem_we at release", word_t'(mem_we), 32'd0);
        @(negedge clk);
        expect_word("im_addr one cycle later", im_addr, RESET_PC + 32'd4);
        expect_word("mem_we one cycle later", word_t'(mem_we), 32'd0);
        report_test("reset", e0, c0);

        wait_for_halt(halted);
        if (!halted) begin
            $display("timeout: fetch never reached the halt loop at %h in %0d cycles",
                     HALT_ADDR, HALT_TIMEOUT);
            error_count++;
        end else begin
            repeat (DRAIN_CYCLES) @(negedge clk);
            run_reg_tests();
        end

        $display("tests: %0d, checks: %0d, errors: %0d", tests_run, check_count, error_count);
        if (error_count == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

// File: verilog.f
logic/cpu_pkg.sv
logic/fetch_stage.sv
logic/reg_file.sv
logic/decode_stage.sv
logic/execute_stage.sv
logic/hazard_unit.sv
logic/mem_wb_stage.sv
logic/cpu_top.sv
dv/cpu_chk.sv
dv/cpu_tb.sv

// File: Makefile
SIM = obj_dir/Vcpu_tb

.PHONY: run clean

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx 'Finished with no errors'

$(SIM): verilog.f logic/*.sv dv/*.sv
	verilator --binary --timing --assert --timescale 1ns/1ps --top-module cpu_tb -f verilog.f

clean:
	rm -rf obj_dir
